/* all.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/uncached_dcache.sv
hdl/line_ram.sv
hdl/dcache_top.sv
test/tb_clock.sv
test/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* test/dcache_tb.sv */
`include "dcache_config.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int LOAD_LAT   = `LINE_RAM_LATENCY + 2;
    localparam int STORE_LAT  = 2;  // posted store acked at write acceptance
    localparam int WAIT_LIMIT = 50;

    logic      clk;
    logic      rst;
    logic      valid;
    cpu_req_t  req;
    logic      flush;
    addr_t     flush_pc;
    logic      cache_ready;
    logic      cache_ack;
    cpu_resp_t resp;

    logic [7:0] ref_mem [4096];    // byte model, address bits 11:0
    logic       ref_known [4096];
    addr_t      pc_next;
    logic       load_pending;      // a load is in flight
    logic       kill_plan;         // current request gets an effective flush
    logic       acked_once;
    word_t      exp_word;
    word_t      exp_mask;
    logic       accept;

    tb_clock #(.PERIOD(100)) clk_gen (.clk(clk));

    dcache_top dcache_top_inst (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .req         (req),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .cache_ready (cache_ready),
        .cache_ack   (cache_ack),
        .resp        (resp)
    );

    assign accept = valid && cache_ack;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped");
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!cache_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!cache_ready) begin
            stop_with_failure("timed out waiting for cache_ready to return");
        end
    endtask

    function automatic cpu_req_t make_req(input logic op, input logic unc, input addr_t a,
                                          input wstrb_t strb, input word_t data);
        cpu_req_t r;
        r.op      = op;
        r.uncache = unc;
        r.pc      = pc_next;
        r.tag     = a[31:32-`DC_TAG_W];
        r.index   = a[`DC_OFFSET_W +: `DC_INDEX_W];
        r.offset  = a[`DC_OFFSET_W-1:0];
        r.wstrb   = strb;
        r.wdata   = data;
        r.rd_type = 3'd2;  // word
        r.wr_type = (strb == 4'hf) ? 3'd2 : (strb == 4'h3 || strb == 4'hc) ? 3'd1 : 3'd0;
        return r;
    endfunction

    // one request from acceptance through an optional LOOK_UP flush back to ready
    task automatic issue(input cpu_req_t r, input logic use_flush, input addr_t fpc);
        int n;
        wait_ready();
        @(posedge clk);
        kill_plan = use_flush && (fpc <= r.pc);
        valid <= 1'b1;
        req   <= r;
        n = 0;
        @(negedge clk);
        while (!cache_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!cache_ack) begin
            stop_with_failure("timed out waiting for cache_ack");
        end
        @(posedge clk);  // acceptance edge
        valid      <= 1'b0;
        acked_once <= 1'b1;
        flush      <= use_flush;
        flush_pc   <= fpc;
        @(posedge clk);
        flush <= 1'b0;
        wait_ready();
    endtask

    task automatic store_word(input addr_t a, input wstrb_t strb, input word_t data,
                              input logic unc, input logic use_flush, input addr_t fpc);
        cpu_req_t r;
        int       base;
        r = make_req(1'b1, unc, a, strb, data);
        pc_next = pc_next + 32'd4;
        load_pending = 1'b0;
        issue(r, use_flush, fpc);
        if (!kill_plan) begin
            base = int'(a[11:2]) * 4;
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_mem[base + b]   = data[b*8 +: 8];
                    ref_known[base + b] = 1'b1;
                end
            end
        end
    endtask

    task automatic load_word(input addr_t a, input logic unc, input logic use_flush,
                             input addr_t fpc);
        cpu_req_t r;
        int       base;
        r = make_req(1'b0, unc, a, 4'h0, 32'h0);
        pc_next = pc_next + 32'd4;
        base = int'(a[11:2]) * 4;
        for (int b = 0; b < 4; b++) begin
            exp_word[b*8 +: 8] = ref_mem[base + b];
            exp_mask[b*8 +: 8] = ref_known[base + b] ? 8'hff : 8'h00;  // unwritten bytes skipped
        end
        load_pending = 1'b1;
        issue(r, use_flush, fpc);
        load_pending = 1'b0;
    endtask

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> cache_ready)
        else stop_with_failure($sformatf("Fail cache_ready: got %h, expected 1",
                                         $sampled(cache_ready)));

    // valid is only raised while the front end is idle
    a_ack_when_idle: assert property (@(posedge clk) disable iff (rst)
        cache_ack == valid)
        else stop_with_failure($sformatf("Fail cache_ack: got %h, expected %h",
                                         $sampled(cache_ack), $sampled(valid)));

    a_quiet_until_ack: assert property (@(posedge clk) disable iff (rst)
        !acked_once |-> (!resp.addr_ok && !resp.data_ok))
        else stop_with_failure($sformatf("Fail resp.addr_ok/data_ok: got %h/%h, expected 0/0",
                                         $sampled(resp.addr_ok), $sampled(resp.data_ok)));

    a_lookup_quiet: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##1 (!resp.addr_ok && !resp.data_ok))
        else stop_with_failure($sformatf(
            "Fail resp.addr_ok/data_ok: got %h/%h, expected 0/0 in LOOK_UP",
            $sampled(resp.addr_ok), $sampled(resp.data_ok)));

    a_load_not_early: assert property (@(posedge clk) disable iff (rst)
        (accept && !req.op) |-> ##(LOAD_LAT - 1) (!resp.addr_ok && !resp.data_ok))
        else stop_with_failure($sformatf(
            "Fail resp.addr_ok/data_ok: got %h/%h, expected 0/0 before return",
            $sampled(resp.addr_ok), $sampled(resp.data_ok)));

    a_load_timing: assert property (@(posedge clk) disable iff (rst)
        (accept && !req.op && !kill_plan) |-> ##(LOAD_LAT) (resp.addr_ok && resp.data_ok))
        else stop_with_failure($sformatf(
            "Fail resp.addr_ok/data_ok: got %h/%h, expected 1/1 for load",
            $sampled(resp.addr_ok), $sampled(resp.data_ok)));

    a_store_timing: assert property (@(posedge clk) disable iff (rst)
        (accept && req.op && !kill_plan) |-> ##(STORE_LAT) (resp.addr_ok && resp.data_ok))
        else stop_with_failure($sformatf(
            "Fail resp.addr_ok/data_ok: got %h/%h, expected 1/1 for store",
            $sampled(resp.addr_ok), $sampled(resp.data_ok)));

    a_cancel: assert property (@(posedge clk) disable iff (rst)
        (accept && kill_plan) |-> ##2 (!resp.addr_ok && !resp.data_ok && cache_ready))
        else stop_with_failure($sformatf(
            "Fail cache_ready/resp.addr_ok/data_ok after flush: got %h/%h/%h, expected 1/0/0",
            $sampled(cache_ready), $sampled(resp.addr_ok), $sampled(resp.data_ok)));

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        (resp.data_ok && load_pending) |-> ((resp.rdata & exp_mask) == (exp_word & exp_mask)))
        else stop_with_failure($sformatf("Fail resp.rdata: got %h, expected %h, byte mask %h",
                                         $sampled(resp.rdata), exp_word, exp_mask));

    initial begin
        addr_t  a;
        logic   unc;
        int     choice;
        void'($urandom(32'hab44_be54));
        rst          = 1'b1;
        valid        = 1'b0;
        req          = '0;
        flush        = 1'b0;
        flush_pc     = '0;
        pc_next      = 32'h0000_1000;
        load_pending = 1'b0;
        kill_plan    = 1'b0;
        acked_once   = 1'b0;
        exp_word     = '0;
        exp_mask     = '0;
        for (int i = 0; i < 4096; i++) begin
            ref_known[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);  // idle with nothing to answer yet

        for (int ln = 0; ln < 4; ln++) begin  // every word lane of one line
            a = {20'h12345, 8'h20, 2'(ln), 2'b00};
            store_word(a, 4'hf, $urandom, 1'b0, 1'b0, '0);
            load_word(a, 1'b0, 1'b0, '0);
        end

        a = {20'h0abcd, 8'h21, 4'h4};  // byte merge within one word
        store_word(a, 4'hf, $urandom, 1'b0, 1'b0, '0);
        for (int k = 0; k < 4; k++) begin
            store_word(a, 4'($urandom_range(1, 14)), $urandom, k[0], 1'b0, '0);
        end
        load_word(a, 1'b0, 1'b0, '0);

        a = {20'h00042, 8'h22, 4'h8};
        store_word(a, 4'hf, 32'h1122_3344, 1'b0, 1'b0, '0);
        store_word(a, 4'hf, 32'hdead_beef, 1'b0, 1'b1, pc_next);  // flush at own pc
        store_word(a, 4'h3, 32'h5566_7788, 1'b1, 1'b1, pc_next - 32'd8);
        load_word(a, 1'b0, 1'b1, pc_next);
        load_word(a, 1'b0, 1'b1, pc_next + 32'd4);  // younger flush point so the load survives
        store_word(a, 4'h6, 32'h99aa_bbcc, 1'b0, 1'b1, pc_next + 32'd4);
        load_word(a, 1'b1, 1'b0, '0);

        for (int i = 0; i < 60; i++) begin
            a = {20'($urandom), 6'h0c, 2'($urandom_range(0, 3)), 2'($urandom_range(0, 3)),
                 2'b00};
            unc    = 1'($urandom);
            choice = $urandom_range(0, 7);
            if (choice < 3) begin
                store_word(a, 4'($urandom_range(1, 15)), $urandom, unc, 1'b0, '0);
            end else if (choice == 3) begin
                store_word(a, 4'($urandom_range(1, 15)), $urandom, unc, 1'b1, pc_next);
            end else if (choice == 4) begin
                load_word(a, unc, 1'b1, pc_next + 32'd8);
            end else begin
                load_word(a, unc, 1'b0, '0);
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* hdl/dcache_top.sv */
module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    input  dcache_pkg::cpu_req_t  req,
    input  logic                  flush,
    input  dcache_pkg::addr_t     flush_pc,
    output logic                  cache_ready,
    output logic                  cache_ack,
    output dcache_pkg::cpu_resp_t resp
);
    import dcache_pkg::*;

    // line bus between front end and memory
    logic    rd_req;
    rd_cmd_t rd_cmd;
    logic    rd_rdy;
    logic    ret_valid;
    logic    ret_last;
    line_t   ret_data;
    logic    wr_req;
    wr_cmd_t wr_cmd;
    logic    wr_rdy;
    logic    wr_done;

    uncached_dcache u_dcache (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .req         (req),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .cache_ready (cache_ready),
        .cache_ack   (cache_ack),
        .resp        (resp),
        .rd_req      (rd_req),
        .rd_cmd      (rd_cmd),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .wr_req      (wr_req),
        .wr_cmd      (wr_cmd),
        .wr_rdy      (wr_rdy),
        .wr_done     (wr_done)
    );

    line_ram u_line_ram (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_cmd    (rd_cmd),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_cmd    (wr_cmd),
        .wr_rdy    (wr_rdy),
        .wr_done   (wr_done)
    );

endmodule

/* hdl/line_ram.sv */
`include "dcache_config.svh"

module line_ram #(
    parameter int LINES = `LINE_RAM_LINES
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                rd_req,
    input  dcache_pkg::rd_cmd_t rd_cmd,
    output logic                rd_rdy,
    output logic                ret_valid,
    output logic                ret_last,
    output dcache_pkg::line_t   ret_data,

    input  logic                wr_req,
    input  dcache_pkg::wr_cmd_t wr_cmd,
    output logic                wr_rdy,
    output logic                wr_done
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(LINES);
    localparam int LAT   = `LINE_RAM_LATENCY;
    localparam int CNT_W = $clog2(LAT + 1);

    line_t            mem [LINES];
    line_t            rd_line;       // captured at acceptance
    logic             busy;
    logic             is_wr;         // kind of the op in flight
    logic [CNT_W-1:0] cnt;
    logic             last_cycle;
    logic             rd_accept;
    logic             wr_accept;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_rdy = !busy;
    assign wr_rdy = !busy && !rd_req;  // reads win a tie

    assign rd_accept = rd_req && rd_rdy;
    assign wr_accept = wr_req && wr_rdy;

    assign rd_idx = rd_cmd.addr[4 +: IDX_W];  // line number without the offset
    assign wr_idx = wr_cmd.addr[4 +: IDX_W];

    assign last_cycle = busy && (cnt == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            is_wr <= 1'b0;
            cnt   <= '0;
        end else if (rd_accept || wr_accept) begin
            busy  <= 1'b1;
            is_wr <= wr_accept;
            cnt   <= CNT_W'(LAT);
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (last_cycle) begin
                busy <= 1'b0;
            end
        end
    end

    // byte-masked merge where untouched bytes keep their value
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            for (int b = 0; b < 16; b++) begin
                if (wr_cmd.strb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wr_cmd.data[b*8 +: 8];
                end
            end
        end
        if (rd_accept) begin
            rd_line <= mem[rd_idx];
        end
    end

    assign ret_valid = last_cycle && !is_wr;
    assign ret_last  = ret_valid;   // single beat per read
    assign ret_data  = rd_line;
    assign wr_done   = last_cycle && is_wr;

    a_no_accept_busy: assert property (
        @(posedge clk) disable iff (rst) (rd_accept || wr_accept) |-> (cnt == '0)
    ) else $error("line memory accepted a request while busy");

endmodule

/* hdl/uncached_dcache.sv */
module uncached_dcache (
    input  logic                  clk,
    input  logic                  rst,

    // CPU memory stage
    input  logic                  valid,
    input  dcache_pkg::cpu_req_t  req,
    input  logic                  flush,
    input  dcache_pkg::addr_t     flush_pc,
    output logic                  cache_ready,
    output logic                  cache_ack,
    output dcache_pkg::cpu_resp_t resp,

    // line bus, read channel
    output logic                  rd_req,
    output dcache_pkg::rd_cmd_t   rd_cmd,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  dcache_pkg::line_t     ret_data,

    // line bus, write channel
    output logic                  wr_req,
    output dcache_pkg::wr_cmd_t   wr_cmd,
    input  logic                  wr_rdy,
    input  logic                  wr_done
);
    import dcache_pkg::*;

    dc_state_t  state;
    dc_state_t  next_state;

    cpu_req_t   req_buf;        // held request payload
    logic       req_buf_valid;
    addr_t      req_addr;
    logic [1:0] lane;           // word lane within the line
    logic [1:0] rd_lane_q;      // lane of the read in flight

    logic       flush_hit;
    logic       flush_kill;
    logic       accept;
    logic       read_done;
    logic       write_taken;

    assign accept   = valid && cache_ack;
    assign req_addr = {req_buf.tag, req_buf.index, req_buf.offset};
    assign lane     = req_addr[3:2];

    // younger-or-equal pc than the flush point gets cancelled
    assign flush_hit  = flush && req_buf_valid && (flush_pc <= req_buf.pc);
    // a store on the bus must finish
    assign flush_kill = flush_hit && (state != WRITE_REQ) && (state != WRITE_WAIT);

    assign cache_ack   = valid && (state == IDLE);
    assign cache_ready = (state == IDLE) && !req_buf_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    next_state = LOOK_UP;
                end
            end
            LOOK_UP: begin
                if (!req_buf_valid || flush_hit) begin
                    next_state = IDLE;  // cancelled before the bus
                end else if (req_buf.op) begin
                    next_state = WRITE_REQ;
                end else begin
                    next_state = READ_REQ;
                end
            end
            READ_REQ: begin
                if (rd_rdy) begin
                    next_state = READ_WAIT;
                end
            end
            READ_WAIT: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            WRITE_REQ: begin
                if (wr_rdy) begin
                    next_state = WRITE_WAIT;
                end
            end
            WRITE_WAIT: begin
                if (wr_done) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_buf_valid <= 1'b0;
        end else if (accept) begin
            req_buf_valid <= 1'b1;
        end else if (flush_kill || next_state == IDLE) begin
            req_buf_valid <= 1'b0;
        end
    end

    // payload stays put after a flush so a pending read command holds steady
    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && rd_rdy) begin
            rd_lane_q <= lane;
        end
    end

    assign rd_req          = (state == READ_REQ);
    assign rd_cmd.cmd_type = req_buf.uncache ? req_buf.rd_type : ACC_LINE;
    assign rd_cmd.addr     = req_addr;

    assign wr_req          = (state == WRITE_REQ);
    assign wr_cmd.cmd_type = req_buf.uncache ? req_buf.wr_type : ACC_LINE;
    assign wr_cmd.addr     = req_addr;
    assign wr_cmd.data     = line_t'(req_buf.wdata) << {lane, 5'b0};  // word into its lane
    assign wr_cmd.strb     = lstrb_t'(req_buf.wstrb) << {lane, 2'b0};

    // a killed read still drains its return beat without a response
    assign read_done   = (state == READ_WAIT) && ret_valid && req_buf_valid;
    assign write_taken = (state == WRITE_REQ) && wr_rdy;  // posted store

    assign resp.addr_ok = read_done || write_taken;
    assign resp.data_ok = read_done || write_taken;
    assign resp.rdata   = ret_data[{rd_lane_q, 5'b0} +: 32];

    a_bus_one_channel: assert property (
        @(posedge clk) disable iff (rst)
        (rd_req || wr_req) |-> ({rd_req, wr_req} == {!req_buf.op, req_buf.op})
    ) else $error("bus request does not match the buffered operation");

    a_data_ok_state: assert property (
        @(posedge clk) disable iff (rst)
        resp.data_ok |-> (req_buf_valid && (state == READ_WAIT || state == WRITE_REQ))
    ) else $error("data_ok for an empty buffer or outside READ_WAIT/WRITE_REQ");

    a_single_beat: assert property (
        @(posedge clk) disable iff (rst) ret_valid |-> ret_last
    ) else $error("multi-beat return from line memory");

endmodule

/* hdl/dcache_pkg.sv */
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;
    typedef logic [3:0]   wstrb_t;   // byte mask within a word
    typedef logic [15:0]  lstrb_t;   // byte mask within a line
    typedef logic [2:0]   acc_type_t;

    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;

    localparam acc_type_t ACC_LINE = 3'b100;  // full line transfer

    typedef struct packed {
        logic      op;       // 1 = store
        logic      uncache;
        addr_t     pc;
        tag_t      tag;      // already translated
        index_t    index;
        offset_t   offset;
        wstrb_t    wstrb;
        word_t     wdata;
        acc_type_t rd_type;
        acc_type_t wr_type;
    } cpu_req_t;

    typedef struct packed {
        acc_type_t cmd_type;
        addr_t     addr;
    } rd_cmd_t;

    typedef struct packed {
        acc_type_t cmd_type;
        addr_t     addr;
        lstrb_t    strb;
        line_t     data;
    } wr_cmd_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } cpu_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOK_UP,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ,
        WRITE_WAIT
    } dc_state_t;

endpackage

/* hdl/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address split as tag | index | offset
`define DC_TAG_W      20
`define DC_INDEX_W    8
`define DC_OFFSET_W   4

// backing line memory
`define LINE_RAM_LINES    256  // 16-byte lines
`define LINE_RAM_LATENCY  3    // cycles from acceptance to response

`endif
